//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' compile.f)
HDRS := rtl/fetch_params.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) compile.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f compile.f

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_addr_gen.sv
rtl/parcel_queue.sv
rtl/insn_expander.sv
rtl/fetch_output_stage.sv
rtl/fetch_top.sv
sim/tb_fetch.sv

//--- rtl/fetch_addr_gen.sv
/* linear fetch address generator
   only the first fetch after a redirect may be halfword aligned */
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_addr_gen
  import fetch_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   imem_ack_i,
  input  logic                   redirect_i,
  input  logic [`FETCH_XLEN-1:0] redirect_pc_i,
  input  logic                   queue_almost_full_i,
  output logic [`FETCH_XLEN-1:0] imem_adr_o,
  output logic                   imem_req_o,
  output logic                   imem_flush_o
);

  addr_t nxt_word_adr;

  // memory drops its words in flight along with the queue
  assign imem_flush_o = redirect_i;

  // hold off while the queue can't take more in-flight words
  assign imem_req_o = ~queue_almost_full_i & ~redirect_i;

  // next aligned word, bit 1 of a halfword target goes away here
  assign nxt_word_adr = {imem_adr_o[`FETCH_XLEN-1:2] + 1'b1, 2'b00};

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      imem_adr_o <= `FETCH_PC_INIT;
    else if (redirect_i)
      imem_adr_o <= {redirect_pc_i[`FETCH_XLEN-1:1], 1'b0}; // bit 1 kept
    else if (imem_req_o && imem_ack_i)
      imem_adr_o <= nxt_word_adr;                           // address accepted
  end

endmodule

//--- rtl/fetch_output_stage.sv
/* length decode at the queue head and the registered output to decode
   an instruction is only taken once two parcels sit in the queue */
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_output_stage
  import fetch_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  queue_head_t            head_i,
  input  logic                   almost_empty_i,
  input  logic                   stall_i,
  input  logic                   redirect_i,
  input  logic [`FETCH_XLEN-1:0] redirect_pc_i,
  output logic [1:0]             rd_cnt_o,
  output fetch_insn_t            insn_o
);

  logic                   head_valid;
  logic                   is_rvc;
  logic                   take;
  logic                   fault;
  logic [`FETCH_XLEN-1:0] exp_instr;
  logic                   exp_illegal;
  addr_t                  nxt_pc;    // pc of the head instruction

  insn_expander u_expander (
    .parcels_i (head_i.parcels),
    .instr_o   (exp_instr),
    .illegal_o (exp_illegal)
  );

  assign is_rvc     = head_i.parcels[1:0] != 2'b11;
  assign head_valid = ~almost_empty_i;
  assign take       = head_valid & ~stall_i;
  assign rd_cnt_o   = take ? (is_rvc ? 2'd1 : 2'd2) : 2'd0;

  // only parcels this instruction uses
  assign fault = is_rvc ? head_i.error[0] : |head_i.error;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      nxt_pc <= `FETCH_PC_INIT;
    else if (redirect_i)
      nxt_pc <= {redirect_pc_i[`FETCH_XLEN-1:1], 1'b0};
    else if (take)
      nxt_pc <= nxt_pc + (is_rvc ? addr_t'(2) : addr_t'(4));
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      insn_o.instr        <= NOP;
      insn_o.pc           <= `FETCH_PC_INIT;
      insn_o.bubble       <= 1'b1;
      insn_o.illegal      <= 1'b0;
      insn_o.access_fault <= 1'b0;
    end
    else if (redirect_i)
      insn_o.bubble <= 1'b1;           // head belongs to the old stream
    else if (!stall_i)
    begin
      insn_o.bubble       <= ~head_valid;
      insn_o.illegal      <= head_valid & exp_illegal;
      insn_o.access_fault <= head_valid & fault;
      if (head_valid)
      begin
        insn_o.instr <= exp_instr;     // bubbles keep the last one
        insn_o.pc    <= nxt_pc;
      end
    end
  end

endmodule

//--- rtl/fetch_params.svh
/* sizing of the RV32C fetch unit
   the full threshold must leave room for every word still in flight */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// datapath widths
`define FETCH_XLEN            32
`define FETCH_PARCEL_W        16

// first fetch address out of reset
`define FETCH_PC_INIT         'h200

// memory words that may be outstanding
`define FETCH_INFLIGHT        3

// queue size in parcels (3 words of room per word in flight)
`define FETCH_QUEUE_DEPTH     (3 * `FETCH_INFLIGHT * `FETCH_XLEN / `FETCH_PARCEL_W)

// request stops here so in-flight words plus one still fit
`define FETCH_FULL_THRESHOLD  \
  (`FETCH_QUEUE_DEPTH - (`FETCH_INFLIGHT + 1) * `FETCH_XLEN / `FETCH_PARCEL_W)

`endif

//--- rtl/fetch_pkg.sv
/* types shared by the fetch unit
   encode helpers build the base RV32 formats only */
`include "fetch_params.svh"

package fetch_pkg;

  typedef logic [`FETCH_XLEN-1:0]     addr_t;
  typedef logic [`FETCH_PARCEL_W-1:0] parcel_t;

  // one word as the memory returns it
  typedef struct packed {
    logic [`FETCH_XLEN-1:0] data;
    logic [1:0]             valid;   // per parcel
    logic                   error;   // bus error on the whole word
  } fetch_word_t;

  // two oldest parcels of the queue
  typedef struct packed {
    logic [`FETCH_XLEN-1:0] parcels; // [15:0] is the oldest
    logic [1:0]             error;
  } queue_head_t;

  // towards decode
  typedef struct packed {
    logic [`FETCH_XLEN-1:0] instr;
    addr_t                  pc;
    logic                   bubble;
    logic                   illegal;
    logic                   access_fault;
  } fetch_insn_t;

  // RV32C integer ops
  typedef enum logic [4:0] {
    C_ADDI4SPN, C_LW, C_SW,                              // quadrant 0
    C_ADDI, C_JAL, C_LI, C_LUI,                          // q1 ADDI is also NOP, LUI also ADDI16SP
    C_SRLI, C_SRAI, C_ANDI, C_SUB, C_XOR, C_OR, C_AND,   // q1 misc alu
    C_J, C_BEQZ, C_BNEZ,
    C_SLLI, C_LWSP, C_JR, C_JALR, C_SWSP,                // q2 JR is also MV, JALR also ADD
    C_ILLEGAL
  } rvc_op_e;

  // RV32 major opcodes
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  localparam logic [31:0] NOP    = 32'h0000_0013;  // addi x0,x0,0
  localparam logic [31:0] EBREAK = 32'h0010_0073;

  function automatic logic [31:0] encode_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] encode_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] encode_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [6:0] opc);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
  endfunction

  // imm[0] is dropped
  function automatic logic [31:0] encode_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [6:0] opc);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
  endfunction

  // imm holds bits [31:12]
  function automatic logic [31:0] encode_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] encode_j(logic [20:0] imm, logic [4:0] rd, logic [6:0] opc);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
  endfunction

endpackage

//--- rtl/fetch_top.sv
/* instruction fetch unit of an RV32C core
   memory returns words in order and drops words in flight on imem_flush_o */
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_top
  import fetch_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   imem_ack_i,
  input  fetch_word_t            imem_word_i,
  input  logic                   redirect_i,
  input  logic [`FETCH_XLEN-1:0] redirect_pc_i,
  input  logic                   stall_i,
  output logic [`FETCH_XLEN-1:0] imem_adr_o,
  output logic                   imem_req_o,
  output logic                   imem_flush_o,
  output fetch_insn_t            insn_o
);

  logic        queue_almost_full;
  logic        queue_almost_empty;
  queue_head_t queue_head;
  logic [1:0]  queue_rd_cnt;     // parcels taken by decode

  fetch_addr_gen u_addr_gen (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .imem_ack_i          (imem_ack_i),
    .redirect_i          (redirect_i),
    .redirect_pc_i       (redirect_pc_i),
    .queue_almost_full_i (queue_almost_full),
    .imem_adr_o          (imem_adr_o),
    .imem_req_o          (imem_req_o),
    .imem_flush_o        (imem_flush_o)
  );

  parcel_queue u_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (redirect_i),
    .word_i         (imem_word_i),
    .rd_cnt_i       (queue_rd_cnt),
    .head_o         (queue_head),
    .almost_empty_o (queue_almost_empty),
    .almost_full_o  (queue_almost_full)
  );

  fetch_output_stage u_output (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .head_i         (queue_head),
    .almost_empty_i (queue_almost_empty),
    .stall_i        (stall_i),
    .redirect_i     (redirect_i),
    .redirect_pc_i  (redirect_pc_i),
    .rd_cnt_o       (queue_rd_cnt),
    .insn_o         (insn_o)
  );

endmodule

//--- rtl/insn_expander.sv
/* RV32C to RV32 expansion, integer forms only
   reserved encodings come out zero-extended with illegal_o set */
`timescale 1ns/1ps
`include "fetch_params.svh"

module insn_expander
  import fetch_pkg::*;
(
  input  logic [`FETCH_XLEN-1:0] parcels_i,
  output logic [`FETCH_XLEN-1:0] instr_o,
  output logic                   illegal_o
);

  parcel_t     p;
  rvc_op_e     op;
  logic [4:0]  rd, rs2;
  logic [4:0]  rdp, rs1p;      // 3 bit register forms x8..x15
  logic [11:0] imm_ci, imm_lw, imm_lwsp, imm_swsp;
  logic [11:0] imm_4spn, imm_16sp;
  logic [19:0] imm_lui;
  logic [12:0] imm_b;
  logic [20:0] imm_j;

  assign p    = parcels_i[`FETCH_PARCEL_W-1:0];
  assign rd   = p[11:7];
  assign rs2  = p[6:2];
  assign rdp  = {2'b01, p[4:2]};   // also rs2'
  assign rs1p = {2'b01, p[9:7]};   // also rd' of CB and CA

  // immediates as the spec scatters them
  assign imm_ci   = {{7{p[12]}}, p[6:2]};
  assign imm_lw   = {5'b0, p[5], p[12:10], p[6], 2'b00};
  assign imm_lwsp = {4'b0, p[3:2], p[12], p[6:4], 2'b00};
  assign imm_swsp = {4'b0, p[8:7], p[12:9], 2'b00};
  assign imm_4spn = {2'b0, p[10:7], p[12:11], p[5], p[6], 2'b00};
  assign imm_16sp = {{3{p[12]}}, p[4:3], p[5], p[2], p[6], 4'b0000};
  assign imm_lui  = {{14{p[12]}}, p[12], p[6:2]};
  assign imm_b    = {{5{p[12]}}, p[6:5], p[2], p[11:10], p[4:3], 1'b0};
  assign imm_j    = {{10{p[12]}}, p[8], p[10:9], p[6], p[7], p[2], p[11], p[5:3], 1'b0};

  //////////////////////////////////////////////////
  // opcode decode on quadrant and funct3

  always_comb
  begin
    case ({p[1:0], p[15:13]})
      5'b00_000: op = C_ADDI4SPN;
      5'b00_010: op = C_LW;
      5'b00_110: op = C_SW;
      5'b01_000: op = C_ADDI;
      5'b01_001: op = C_JAL;
      5'b01_010: op = C_LI;
      5'b01_011: op = C_LUI;
      5'b01_100:
        case (p[11:10])
          2'b00:   op = p[12] ? C_ILLEGAL : C_SRLI;  // shamt[5] reserved on RV32
          2'b01:   op = p[12] ? C_ILLEGAL : C_SRAI;
          2'b10:   op = C_ANDI;
          default:
            case ({p[12], p[6:5]})
              3'b000:  op = C_SUB;
              3'b001:  op = C_XOR;
              3'b010:  op = C_OR;
              3'b011:  op = C_AND;
              default: op = C_ILLEGAL;              // subw/addw, RV64 only
            endcase
        endcase
      5'b01_101: op = C_J;
      5'b01_110: op = C_BEQZ;
      5'b01_111: op = C_BNEZ;
      5'b10_000: op = p[12] ? C_ILLEGAL : C_SLLI;
      5'b10_010: op = C_LWSP;
      5'b10_100: op = p[12] ? C_JALR : C_JR;
      5'b10_110: op = C_SWSP;
      default:   op = C_ILLEGAL;                      // fp forms land here too
    endcase
  end

  //////////////////////////////////////////////////
  // expansion

  always_comb
  begin
    instr_o   = {16'h0000, p};   // reserved forms
    illegal_o = 1'b0;
    if (parcels_i[1:0] == 2'b11)
      instr_o = parcels_i;       // already 32 bit
    else
      case (op)
        C_ADDI4SPN:
          if (imm_4spn == '0)
            illegal_o = 1'b1;    // includes the all zero parcel
          else
            instr_o = encode_i(imm_4spn, 5'd2, 3'b000, rdp, OPC_OP_IMM);
        C_LW:   instr_o = encode_i(imm_lw, rs1p, 3'b010, rdp, OPC_LOAD);
        C_SW:   instr_o = encode_s(imm_lw, rdp, rs1p, 3'b010, OPC_STORE);
        C_ADDI: instr_o = encode_i(imm_ci, rd, 3'b000, rd, OPC_OP_IMM);   // rd 0 is c.nop
        C_JAL:  instr_o = encode_j(imm_j, 5'd1, OPC_JAL);
        C_LI:   instr_o = encode_i(imm_ci, 5'd0, 3'b000, rd, OPC_OP_IMM);
        C_LUI:
          if (imm_ci[5:0] == '0)
            illegal_o = 1'b1;
          else if (rd == 5'd2)
            instr_o = encode_i(imm_16sp, 5'd2, 3'b000, 5'd2, OPC_OP_IMM);
          else
            instr_o = encode_u(imm_lui, rd, OPC_LUI);                 // rd 0 is a hint
        C_SRLI: instr_o = encode_i({7'b0000000, rs2}, rs1p, 3'b101, rs1p, OPC_OP_IMM);
        C_SRAI: instr_o = encode_i({7'b0100000, rs2}, rs1p, 3'b101, rs1p, OPC_OP_IMM);
        C_ANDI: instr_o = encode_i(imm_ci, rs1p, 3'b111, rs1p, OPC_OP_IMM);
        C_SUB:  instr_o = encode_r(7'b0100000, rdp, rs1p, 3'b000, rs1p, OPC_OP);
        C_XOR:  instr_o = encode_r(7'b0000000, rdp, rs1p, 3'b100, rs1p, OPC_OP);
        C_OR:   instr_o = encode_r(7'b0000000, rdp, rs1p, 3'b110, rs1p, OPC_OP);
        C_AND:  instr_o = encode_r(7'b0000000, rdp, rs1p, 3'b111, rs1p, OPC_OP);
        C_J:    instr_o = encode_j(imm_j, 5'd0, OPC_JAL);
        C_BEQZ: instr_o = encode_b(imm_b, 5'd0, rs1p, 3'b000, OPC_BRANCH);
        C_BNEZ: instr_o = encode_b(imm_b, 5'd0, rs1p, 3'b001, OPC_BRANCH);
        C_SLLI: instr_o = encode_i({7'b0000000, rs2}, rd, 3'b001, rd, OPC_OP_IMM);
        C_LWSP:
          if (rd == '0)
            illegal_o = 1'b1;
          else
            instr_o = encode_i(imm_lwsp, 5'd2, 3'b010, rd, OPC_LOAD);
        C_SWSP: instr_o = encode_s(imm_swsp, rs2, 5'd2, 3'b010, OPC_STORE);
        C_JR:
          if (rs2 != '0)
            instr_o = encode_r(7'b0000000, rs2, 5'd0, 3'b000, rd, OPC_OP);  // c.mv
          else if (rd == '0)
            illegal_o = 1'b1;
          else
            instr_o = encode_i(12'd0, rd, 3'b000, 5'd0, OPC_JALR);
        C_JALR:
          if (rs2 != '0)
            instr_o = encode_r(7'b0000000, rs2, rd, 3'b000, rd, OPC_OP);    // c.add
          else if (rd == '0)
            instr_o = EBREAK;
          else
            instr_o = encode_i(12'd0, rd, 3'b000, 5'd1, OPC_JALR);
        default: illegal_o = 1'b1;
      endcase
  end

endmodule

//--- rtl/parcel_queue.sv
/* parcel FIFO, one word in and up to two parcels out per cycle
   no overflow check, the fetch threshold keeps room for words in flight */
`timescale 1ns/1ps
`include "fetch_params.svh"

module parcel_queue
  import fetch_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        flush_i,
  input  fetch_word_t word_i,
  input  logic [1:0]  rd_cnt_i,
  output queue_head_t head_o,
  output logic        almost_empty_o,
  output logic        almost_full_o
);

  localparam int unsigned DEPTH = `FETCH_QUEUE_DEPTH;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  parcel_t [DEPTH-1:0] q_par;     // entry 0 is the oldest
  parcel_t [DEPTH-1:0] par_nxt;
  logic    [DEPTH-1:0] q_err;
  logic    [DEPTH-1:0] err_nxt;
  logic    [CNT_W-1:0] cnt;       // fill level in parcels
  logic    [CNT_W-1:0] cnt_left;  // after this cycle's read
  logic    [CNT_W-1:0] hi_pos;
  logic    [CNT_W-1:0] cnt_nxt;

  //////////////////////////////////////////////////
  // read shift and write pack

  always_comb
  begin
    // drop what decode takes this cycle
    par_nxt  = q_par >> (rd_cnt_i * `FETCH_PARCEL_W);
    err_nxt  = q_err >> rd_cnt_i;
    cnt_left = cnt - CNT_W'(rd_cnt_i);

    // valid parcels land in order behind the rest
    hi_pos = cnt_left + CNT_W'(word_i.valid[0]);
    for (int i = 0; i < DEPTH; i++)
    begin
      if (word_i.valid[0] && cnt_left == CNT_W'(i))
      begin
        par_nxt[i] = word_i.data[`FETCH_PARCEL_W-1:0];
        err_nxt[i] = word_i.error;
      end
      if (word_i.valid[1] && hi_pos == CNT_W'(i))
      begin
        par_nxt[i] = word_i.data[`FETCH_XLEN-1:`FETCH_PARCEL_W];
        err_nxt[i] = word_i.error;
      end
    end
    cnt_nxt = hi_pos + CNT_W'(word_i.valid[1]);
  end

  //////////////////////////////////////////////////
  // storage

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      cnt <= '0;
    else if (flush_i)
      cnt <= '0;        // writes of this cycle are lost too
    else
      cnt <= cnt_nxt;
  end

  always_ff @(posedge clk_i)
  begin
    q_par <= par_nxt;
    q_err <= err_nxt;
  end

  assign head_o.parcels = {q_par[1], q_par[0]};
  assign head_o.error   = q_err[1:0];

  // two parcels is enough for any 32 bit instruction
  assign almost_empty_o = cnt < CNT_W'(2);
  assign almost_full_o  = cnt >= CNT_W'(`FETCH_FULL_THRESHOLD);

endmodule

//--- sim/tb_fetch.sv
/* testbench for the RV32C fetch unit, memory model with random ack and latency
   program image below 4 KiB, two segments joined by a halfword redirect */
`timescale 1ns/1ps
`include "fetch_params.svh"

module tb_fetch
  import fetch_pkg::*;
;

  localparam int          N1       = 80;            // instructions from reset pc
  localparam int          N2       = 40;            // instructions after redirect
  localparam logic [31:0] SEG2_PC  = 32'h0000_0802; // halfword target
  localparam logic [31:0] ERR_LO   = 32'h0000_0280; // bus error window
  localparam logic [31:0] ERR_HI   = 32'h0000_0290;
  localparam int          TIMEOUT_CYC = (N1 + N2) * 8 + 200;

  // compressed encodings and their 32 bit forms
  localparam logic [15:0] RVC_ENC [11] = '{16'h0085, 16'h0001, 16'h557D, 16'h85B2,
    16'h95B2, 16'h9002, 16'h8082, 16'h4080, 16'h8C05, 16'h028E, 16'h6185};
  localparam logic [31:0] RVC_EXP [11] = '{32'h0010_8093, 32'h0000_0013, 32'hFFF0_0513,
    32'h00C0_05B3, 32'h00C5_85B3, 32'h0010_0073, 32'h0000_8067, 32'h0004_A403,
    32'h4094_0433, 32'h0032_9293, 32'h0000_11B7};
  // zero parcel, c.lwsp rd0, c.jr rd0, c.addi16sp imm0
  localparam logic [15:0] ILL_ENC [4] = '{16'h0000, 16'h4002, 16'h8002, 16'h6101};

  logic        clk_i = 1'b0;
  logic        rst_ni, imem_ack_i, redirect_i, stall_i;
  logic [31:0] redirect_pc_i;
  fetch_word_t imem_word_i;
  logic [31:0] imem_adr_o;
  logic        imem_req_o, imem_flush_o;
  fetch_insn_t insn_o;

  logic [31:0] mem [0:1023];
  logic [31:0] seed = 32'd39908;
  logic [31:0] exp_pc[$];
  logic [31:0] exp_instr[$];
  logic        exp_ill[$];
  logic        exp_af[$];
  logic [31:0] pend_adr[$];    // words in flight, oldest first
  int          pend_rdy[$];
  int          cyc, last_rdy, rdy;
  int          chk_idx, chk_end;
  int          errors, checks;
  logic [31:0] r_mem, r_drv, a_drv;
  logic        prev_stall, prev_redir;
  fetch_insn_t prev_insn;

  fetch_top UUT (.*);

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  function automatic logic in_err_window(input logic [31:0] a);
    return a >= ERR_LO && a < ERR_HI;
  endfunction

  task automatic check_value(input string name, input logic [66:0] exp, input logic [66:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic put_half(input logic [31:0] a, input logic [15:0] v);
    if (a[1])
      mem[a[11:2]][31:16] = v;
    else
      mem[a[11:2]][15:0] = v;
  endtask

  task automatic push_exp(input logic [31:0] pc, input logic [31:0] instr, input logic ill,
                          input logic wide);
    exp_pc.push_back(pc);
    exp_instr.push_back(instr);
    exp_ill.push_back(ill);
    exp_af.push_back(in_err_window(pc) | (wide & in_err_window(pc + 32'd2)));
  endtask

  // lays out n instructions from start, first 15 cover the illegal and table forms
  task automatic gen_segment(input logic [31:0] start, input int n);
    logic [31:0] pc;
    logic [31:0] r;
    int          sel;
    pc = start;
    for (int k = 0; k < n; k++)
    begin
      r   = lcg_next();
      sel = (k < 15) ? k : int'(r[20:16]);
      if (sel < 4)
      begin
        put_half(pc, ILL_ENC[sel]);
        push_exp(pc, {16'h0000, ILL_ENC[sel]}, 1'b1, 1'b0);
        pc = pc + 32'd2;
      end
      else if (sel < 15)
      begin
        put_half(pc, RVC_ENC[sel-4]);
        push_exp(pc, RVC_EXP[sel-4], 1'b0, 1'b0);
        pc = pc + 32'd2;
      end
      else
      begin
        r = lcg_next() | 32'h3;  // plain 32 bit word
        put_half(pc, r[15:0]);
        put_half(pc + 32'd2, r[31:16]);
        push_exp(pc, r, 1'b0, 1'b1);
        pc = pc + 32'd4;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // memory model

  always @(negedge clk_i)
  begin
    cyc++;
    if (imem_flush_o)
    begin
      pend_adr.delete();  // in-flight words gone
      pend_rdy.delete();
    end
    else if (rst_ni && imem_req_o && imem_ack_i)
    begin
      r_mem = lcg_next();
      rdy   = cyc + 1 + int'(r_mem[17:16] % 2'd3);
      if (pend_rdy.size() > 0 && rdy <= last_rdy)
        rdy = last_rdy + 1;   // keep return order
      last_rdy = rdy;
      pend_adr.push_back(imem_adr_o);
      pend_rdy.push_back(rdy);
    end
  end

  always @(posedge clk_i)
  begin
    #2;
    r_drv       = lcg_next();
    stall_i     = r_drv[9:8] == 2'b00;
    imem_ack_i  = r_drv[13:12] != 2'b00;
    imem_word_i = '0;
    if (pend_adr.size() > 0 && pend_rdy[0] <= cyc)
    begin
      a_drv = pend_adr.pop_front();
      void'(pend_rdy.pop_front());
      imem_word_i.data  = mem[a_drv[11:2]];
      imem_word_i.valid = a_drv[1] ? 2'b10 : 2'b11;   // low parcel skipped
      imem_word_i.error = in_err_window({a_drv[31:2], 2'b00});
    end
  end

  //////////////////////////////////////////////////
  // output checks, sampled mid cycle

  always @(negedge clk_i)
  begin
    if (rst_ni)
    begin
      check_value("flush", 67'(redirect_i), 67'(imem_flush_o));
      if (prev_stall && !prev_redir)
        check_value("stall hold", 67'(prev_insn), 67'(insn_o));
      // fresh, non-bubble output against the next prediction
      if (!prev_stall && !insn_o.bubble && chk_idx < chk_end)
      begin
        check_value("pc", 67'(exp_pc[chk_idx]), 67'(insn_o.pc));
        check_value("instr", 67'(exp_instr[chk_idx]), 67'(insn_o.instr));
        check_value("illegal", 67'(exp_ill[chk_idx]), 67'(insn_o.illegal));
        check_value("access_fault", 67'(exp_af[chk_idx]), 67'(insn_o.access_fault));
        chk_idx++;
      end
    end
    prev_stall = stall_i;
    prev_redir = redirect_i;
    prev_insn  = insn_o;
  end

  initial
  begin
    repeat (TIMEOUT_CYC) @(posedge clk_i);
    $display("watchdog expired, outputs still missing at index %0d", chk_idx);
    $display("checks %0d, errors %0d", checks, errors);
    $display("TESTS FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // stimulus

  initial
  begin
    rst_ni        = 1'b0;
    imem_ack_i    = 1'b0;
    imem_word_i   = '0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    stall_i       = 1'b0;
    for (int i = 0; i < 1024; i++)
      mem[i] = (32'(i) * 32'h9E37_79B1) | 32'h3;  // filler
    gen_segment(32'(`FETCH_PC_INIT), N1);
    gen_segment(SEG2_PC, N2);
    chk_idx = 0;
    chk_end = N1;

    repeat (9) @(posedge clk_i);
    @(negedge clk_i);
    check_value("reset bubble", 67'(1), 67'(insn_o.bubble));
    check_value("reset req", 67'(1), 67'(imem_req_o));
    check_value("reset adr", 67'(32'(`FETCH_PC_INIT)), 67'(imem_adr_o));
    @(posedge clk_i);
    #2 rst_ni = 1'b1;

    while (chk_idx < chk_end)
      @(posedge clk_i);
    @(posedge clk_i);
    #2;
    redirect_i    = 1'b1;
    redirect_pc_i = SEG2_PC;
    @(posedge clk_i);
    #2;
    redirect_i = 1'b0;
    chk_idx    = N1;
    chk_end    = N1 + N2;
    while (chk_idx < chk_end)
      @(posedge clk_i);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule
